//--- build.f
rtl/soc_pkg.sv
rtl/pi1_if.sv
rtl/pi1_router.sv
rtl/scratch_ram.sv
rtl/dev_table.sv
rtl/int_ctrl.sv
rtl/reset_seq.sv
rtl/soc_top.sv
testbench/tb_soc_top.sv

//--- run.sh
#!/bin/sh
# Build and run the soc_top testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_soc_top -f build.f -o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST OK"; then
	exit 0
fi
exit 1

//--- testbench/tb_soc_top.sv
// ----------------------------------------
// Testbench for soc_top with random bus
// traffic checked against RAM and register models
// ----------------------------------------
`timescale 1ns/1ns
`default_nettype none

module tb_soc_top;

	localparam int RST_HOLD = 8;
	localparam int WAIT_LIMIT = 200;
	localparam int AW = soc_pkg::ADDR_BITS;
	// Region bases of the bus map
	localparam logic [AW-1:0] BASE_DEVTBL = 30'd256;
	localparam logic [AW-1:0] BASE_INTCTRL = 30'd320;
	localparam logic [AW-1:0] BASE_INVALID = 30'd336;

	logic clk48mhz;
	logic rst_p;
	logic [1:0] pi1_op;
	logic [AW-1:0] pi1_addr;
	logic [31:0] pi1_wdata;
	logic [3:0] pi1_sel;
	logic [31:0] pi1_rdata;
	logic pi1_rdy;
	logic [1:0] irq_src;
	logic irq;
	logic sys_rst;
	logic halted;

	logic [31:0] lcg_state;
	logic [31:0] ram_model [256];
	logic [1:0] pend_m;
	logic [1:0] en_m;
	// Read result still owed by the DUT
	logic pend_valid;
	logic [31:0] pend_exp;
	string pend_name;
	bit timed_out;
	int checks;
	int errors;
	int test_num;

	soc_top #(
		.RST_HOLD_CYCLES (RST_HOLD)
	) DUT (
		.clk48mhz_i (clk48mhz),
		.rst_p      (rst_p),
		.pi1_op_i   (pi1_op),
		.pi1_addr_i (pi1_addr),
		.pi1_data_i (pi1_wdata),
		.pi1_sel_i  (pi1_sel),
		.pi1_data_o (pi1_rdata),
		.pi1_rdy_o  (pi1_rdy),
		.irq_src_i  (irq_src),
		.irq_o      (irq),
		.sys_rst_o  (sys_rst),
		.halted_o   (halted)
	);

	initial clk48mhz = 1'b0;
	always #20 clk48mhz = ~clk48mhz;

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
		input logic [31:0] new_w, input logic [3:0] sel);
		logic [31:0] res;
		res = old_w;
		for (int b = 0; b < 4; b++) begin
			if (sel[b])
				res[b*8 +: 8] = new_w[b*8 +: 8];
		end
		return res;
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("[FAIL] %0t ns %s: got %h, expected %h", $time, name, got, expected);
		end
	endtask

	// Outputs are sampled at the falling edge
	task automatic to_negedge();
		@(negedge clk48mhz);
		if (pend_valid) begin
			check(pend_name, pi1_rdata, pend_exp);
			pend_valid = 1'b0;
		end
	endtask

	task automatic to_drive();
		@(posedge clk48mhz);
		#2;
	endtask

	task automatic idle_cycle();
		to_negedge();
		to_drive();
	endtask

	// Returns just after the accepting edge so the next call can follow back to back
	task automatic issue(input logic [1:0] op, input logic [AW-1:0] addr,
		input logic [31:0] wdata, input logic [3:0] sel, input logic [31:0] expected,
		input string name);
		int waits;
		bit accepted;
		waits = 0;
		accepted = 1'b0;
		if (timed_out)
			return;
		pi1_op = op;
		pi1_addr = addr;
		pi1_wdata = wdata;
		pi1_sel = sel;
		while (!accepted && !timed_out) begin
			to_negedge();
			if (pi1_rdy) begin
				accepted = 1'b1;
			end else begin
				waits = waits + 1;
				if (waits >= WAIT_LIMIT) begin
					timed_out = 1'b1;
					$display("Timeout: request at address %h never saw ready", addr);
				end
			end
			to_drive();
		end
		pi1_op = soc_pkg::OP_NONE;
		pend_valid = accepted && (op == soc_pkg::OP_READ || op == soc_pkg::OP_SWAP);
		pend_exp = expected;
		pend_name = name;
	endtask

	task automatic ram_access(input logic [1:0] op, input logic [7:0] idx,
		input logic [31:0] wdata, input logic [3:0] sel);
		logic [31:0] old_w;
		old_w = ram_model[idx];
		issue(op, AW'(idx), wdata, sel, old_w, $sformatf("pi1_data_o (RAM word %0d)", idx));
		if (op == soc_pkg::OP_WRITE || op == soc_pkg::OP_SWAP)
			ram_model[idx] = merge_bytes(old_w, wdata, sel);
	endtask

	task automatic verify_ram();
		for (int i = 0; i < 256; i++)
			ram_access(soc_pkg::OP_READ, 8'(i), 32'd0, 4'h0);
		idle_cycle();
	endtask

	// Counts one falling-edge sample per clock while sys_rst_o is high
	task automatic measure_hold(output int cycles);
		bit done;
		cycles = 0;
		done = 1'b0;
		while (!done && !timed_out) begin
			to_drive();
			to_negedge();
			if (!sys_rst) begin
				done = 1'b1;
			end else begin
				check("pi1_rdy_o", 32'(pi1_rdy), 32'd0);
				cycles++;
				if (cycles >= WAIT_LIMIT) begin
					timed_out = 1'b1;
					$display("Timeout: sys_rst_o never went low");
				end
			end
		end
	endtask

	task automatic end_test(input string name, input int errs_before);
		test_num++;
		$display("Test %0d, %s: %0d errors", test_num, name, errors - errs_before);
	endtask

	task automatic reset_release();
		int e0;
		int cycles;
		e0 = errors;
		measure_hold(cycles);
		check("sys_rst_o hold cycles", 32'(cycles), 32'(RST_HOLD));
		check("pi1_rdy_o", 32'(pi1_rdy), 32'd1);
		check("irq_o", 32'(irq), 32'd0);
		check("halted_o", 32'(halted), 32'd0);
		to_drive();
		end_test("reset release", e0);
	endtask

	task automatic ram_traffic();
		int e0;
		logic [31:0] r;
		logic [1:0] op;
		e0 = errors;
		// RAM has no reset so every word gets a known value first
		for (int i = 0; i < 256; i++)
			ram_access(soc_pkg::OP_WRITE, 8'(i), lcg_next() ^ {24'h0, 8'(i)}, 4'hF);
		for (int n = 0; n < 200; n++) begin
			r = lcg_next();
			case (r[31:30])
				2'd0: op = soc_pkg::OP_WRITE;
				2'd1: op = soc_pkg::OP_SWAP;
				default: op = soc_pkg::OP_READ;
			endcase
			ram_access(op, r[27:20], lcg_next(), r[19:16]);
			// Mostly back to back with an occasional gap
			if (r[15:14] == 2'd0)
				idle_cycle();
		end
		idle_cycle();
		end_test("random RAM traffic", e0);
	endtask

	task automatic dev_table_reads();
		int e0;
		logic [31:0] entry [6];
		e0 = errors;
		entry[0] = (32'(soc_pkg::USEINTR_RAM) << 31) | 32'(soc_pkg::DEV_ID_RAM);
		entry[1] = 32'(soc_pkg::MAPSZ_RAM);
		entry[2] = (32'(soc_pkg::USEINTR_DEVTBL) << 31) | 32'(soc_pkg::DEV_ID_DEVTBL);
		entry[3] = 32'(soc_pkg::MAPSZ_DEVTBL);
		entry[4] = (32'(soc_pkg::USEINTR_INTCTRL) << 31) | 32'(soc_pkg::DEV_ID_INTCTRL);
		entry[5] = 32'(soc_pkg::MAPSZ_INTCTRL);
		issue(soc_pkg::OP_READ, BASE_DEVTBL + AW'(soc_pkg::DT_SOCID), 32'd0, 4'h0,
			32'(soc_pkg::SOC_ID), "pi1_data_o (SoC id)");
		issue(soc_pkg::OP_READ, BASE_DEVTBL + AW'(soc_pkg::DT_COUNT), 32'd0, 4'h0,
			32'(soc_pkg::SLAVE_COUNT), "pi1_data_o (slave count)");
		for (int k = 0; k < 6; k++)
			issue(soc_pkg::OP_READ, BASE_DEVTBL + AW'(soc_pkg::DT_ENTRY + k), 32'd0, 4'h0,
				entry[k], $sformatf("pi1_data_o (entry word %0d)", k));
		issue(soc_pkg::OP_READ, BASE_DEVTBL + 30'd63, 32'd0, 4'h0, 32'd0,
			"pi1_data_o (unused word)");
		idle_cycle();
		end_test("device table", e0);
	endtask

	task automatic invalid_region();
		int e0;
		logic [31:0] r;
		logic [AW-1:0] a;
		e0 = errors;
		for (int n = 0; n < 16; n++) begin
			r = lcg_next();
			a = r[31:2];
			if (a < BASE_INVALID)
				a = a + BASE_INVALID;
			issue(soc_pkg::OP_READ, a, 32'd0, 4'h0, 32'd0, "pi1_data_o (invalid read)");
		end
		// Low bits match RAM words so a leaked write would show up
		for (int n = 0; n < 16; n++) begin
			r = lcg_next();
			a = {r[31:13], 1'b1, 2'b00, r[7:0]};
			issue(r[12] ? soc_pkg::OP_SWAP : soc_pkg::OP_WRITE, a, lcg_next(), 4'hF, 32'd0,
				"pi1_data_o (invalid swap)");
		end
		idle_cycle();
		verify_ram();
		end_test("invalid region", e0);
	endtask

	task automatic pulse_sources(input logic [1:0] src);
		logic prev_irq;
		prev_irq = |(pend_m & en_m);
		irq_src = src;
		to_negedge();
		to_drive();
		irq_src = 2'b00;
		pend_m = pend_m | src;
		to_negedge();
		check("irq_o", 32'(irq), 32'(prev_irq));
		to_drive();
		to_negedge();
		check("irq_o", 32'(irq), 32'(|(pend_m & en_m)));
		to_drive();
	endtask

	task automatic interrupts();
		int e0;
		logic [31:0] r;
		logic [1:0] held;
		e0 = errors;
		for (int n = 0; n < 8; n++) begin
			r = lcg_next();
			issue(soc_pkg::OP_WRITE, BASE_INTCTRL + AW'(soc_pkg::IC_ENABLE), 32'(r[21:20]),
				4'hF, 32'd0, "");
			en_m = r[21:20];
			pulse_sources(r[23:22]);
			issue(soc_pkg::OP_READ, BASE_INTCTRL + AW'(soc_pkg::IC_PENDING), 32'd0, 4'h0,
				32'(pend_m), "pi1_data_o (IC pending)");
			issue(soc_pkg::OP_READ, BASE_INTCTRL + AW'(soc_pkg::IC_ENABLE), 32'd0, 4'h0,
				32'(en_m), "pi1_data_o (IC enable)");
			issue(soc_pkg::OP_WRITE, BASE_INTCTRL + AW'(soc_pkg::IC_PENDING), 32'(r[25:24]),
				4'hF, 32'd0, "");
			pend_m = pend_m & ~r[25:24];
		end
		// Clear everything while a source stays high
		r = lcg_next();
		held = (r[17:16] == 2'b00) ? 2'b01 : r[17:16];
		irq_src = held;
		issue(soc_pkg::OP_WRITE, BASE_INTCTRL + AW'(soc_pkg::IC_PENDING), 32'h3, 4'hF, 32'd0, "");
		irq_src = 2'b00;
		pend_m = held;
		issue(soc_pkg::OP_READ, BASE_INTCTRL + AW'(soc_pkg::IC_PENDING), 32'd0, 4'h0,
			32'(pend_m), "pi1_data_o (pending with source held)");
		issue(soc_pkg::OP_WRITE, BASE_INTCTRL + AW'(soc_pkg::IC_PENDING), 32'h3, 4'hF, 32'd0, "");
		pend_m = 2'b00;
		issue(soc_pkg::OP_READ, BASE_INTCTRL + AW'(soc_pkg::IC_PENDING), 32'd0, 4'h0,
			32'd0, "pi1_data_o (pending after clear)");
		to_negedge();
		check("irq_o", 32'(irq), 32'd0);
		to_drive();
		end_test("interrupts", e0);
	endtask

	task automatic software_reset();
		int e0;
		int cycles;
		e0 = errors;
		// Warm reset makes sys_rst_o rise two edges after acceptance
		issue(soc_pkg::OP_WRITE, BASE_DEVTBL + AW'(soc_pkg::DT_RSTCTRL), 32'h2, 4'hF, 32'd0, "");
		to_negedge();
		check("sys_rst_o", 32'(sys_rst), 32'd0);
		to_drive();
		to_negedge();
		check("sys_rst_o", 32'(sys_rst), 32'd0);
		measure_hold(cycles);
		check("sys_rst_o warm hold cycles", 32'(cycles), 32'(RST_HOLD));
		check("halted_o", 32'(halted), 32'd0);
		to_drive();
		pend_m = 2'b00;
		en_m = 2'b00;
		verify_ram();
		// Power-off latches until rst_p
		issue(soc_pkg::OP_WRITE, BASE_DEVTBL + AW'(soc_pkg::DT_RSTCTRL), 32'h1, 4'hF, 32'd0, "");
		to_negedge();
		check("halted_o", 32'(halted), 32'd0);
		to_drive();
		to_negedge();
		check("halted_o", 32'(halted), 32'd0);
		check("sys_rst_o", 32'(sys_rst), 32'd0);
		for (int n = 0; n < 20; n++) begin
			to_drive();
			to_negedge();
			check("halted_o", 32'(halted), 32'd1);
			check("sys_rst_o", 32'(sys_rst), 32'd1);
			check("pi1_rdy_o", 32'(pi1_rdy), 32'd0);
		end
		to_drive();
		rst_p = 1'b1;
		to_negedge();
		to_drive();
		rst_p = 1'b0;
		to_negedge();
		check("halted_o", 32'(halted), 32'd0);
		measure_hold(cycles);
		check("sys_rst_o hold cycles after power-off", 32'(cycles), 32'(RST_HOLD));
		to_drive();
		verify_ram();
		end_test("software reset", e0);
	endtask

	initial begin
		lcg_state = 32'd92;
		rst_p = 1'b1;
		pi1_op = soc_pkg::OP_NONE;
		pi1_addr = '0;
		pi1_wdata = '0;
		pi1_sel = '0;
		irq_src = 2'b00;
		pend_m = 2'b00;
		en_m = 2'b00;
		pend_valid = 1'b0;
		pend_exp = '0;
		pend_name = "";
		timed_out = 1'b0;
		checks = 0;
		errors = 0;
		test_num = 0;
		repeat (5) @(posedge clk48mhz);
		#2;
		rst_p = 1'b0;
		reset_release();
		if (!timed_out)
			ram_traffic();
		if (!timed_out)
			dev_table_reads();
		if (!timed_out)
			invalid_region();
		if (!timed_out)
			interrupts();
		if (!timed_out)
			software_reset();
		if (timed_out)
			$display("Run stopped early because a wait timed out");
		$display("Tests %0d, checks %0d, errors %0d", test_num, checks, errors);
		if (errors == 0 && !timed_out)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- rtl/soc_top.sv
// ----------------------------------------
// Peripheral subsystem top: router, RAM,
// device table, interrupts and reset
// ----------------------------------------
`timescale 1ns/1ns
`default_nettype none

module soc_top #(
	parameter int RST_HOLD_CYCLES = 8
) (
	input logic clk48mhz_i,
	input logic rst_p,
	input logic [1:0] pi1_op_i,
	input logic [soc_pkg::ADDR_BITS-1:0] pi1_addr_i,
	input logic [soc_pkg::ARCH_BITS-1:0] pi1_data_i,
	input logic [soc_pkg::SEL_BITS-1:0] pi1_sel_i,
	output logic [soc_pkg::ARCH_BITS-1:0] pi1_data_o,
	output logic pi1_rdy_o,
	input logic [soc_pkg::INT_SRC_COUNT-1:0] irq_src_i,
	output logic irq_o,
	output logic sys_rst_o,
	output logic halted_o
);

	logic sys_rst;
	logic warm_req;
	logic off_req;

	pi1_if host_bus ();
	pi1_if ram_bus ();
	pi1_if devtbl_bus ();
	pi1_if intc_bus ();

	// External master side
	assign host_bus.op = soc_pkg::pi1_op_t'(pi1_op_i);
	assign host_bus.addr = pi1_addr_i;
	assign host_bus.wdata = pi1_data_i;
	assign host_bus.sel = pi1_sel_i;
	assign pi1_data_o = host_bus.rdata;
	assign pi1_rdy_o = host_bus.rdy;

	assign sys_rst_o = sys_rst;

	pi1_router u_router (
		.clk48mhz_i (clk48mhz_i),
		.sys_rst_i  (sys_rst),
		.host       (host_bus),
		.ram        (ram_bus),
		.devtbl     (devtbl_bus),
		.intc       (intc_bus)
	);

	scratch_ram u_ram (
		.clk48mhz_i (clk48mhz_i),
		.sys_rst_i  (sys_rst),
		.bus        (ram_bus)
	);

	dev_table u_devtbl (
		.clk48mhz_i (clk48mhz_i),
		.sys_rst_i  (sys_rst),
		.bus        (devtbl_bus),
		.warm_req_o (warm_req),
		.off_req_o  (off_req)
	);

	int_ctrl u_intc (
		.clk48mhz_i (clk48mhz_i),
		.sys_rst_i  (sys_rst),
		.bus        (intc_bus),
		.irq_src_i  (irq_src_i),
		.irq_o      (irq_o)
	);

	reset_seq #(
		.RST_HOLD_CYCLES (RST_HOLD_CYCLES)
	) u_rst (
		.clk48mhz_i (clk48mhz_i),
		.rst_p      (rst_p),
		.warm_req_i (warm_req),
		.off_req_i  (off_req),
		.sys_rst_o  (sys_rst),
		.halted_o   (halted_o)
	);

endmodule

`default_nettype wire

//--- rtl/reset_seq.sv
// ----------------------------------------
// Reset sequencer with hold counter, warm
// restart and power-off latch
// ----------------------------------------
`timescale 1ns/1ns
`default_nettype none

module reset_seq #(
	parameter int RST_HOLD_CYCLES = 8
) (
	input logic clk48mhz_i,
	input logic rst_p,
	input logic warm_req_i,
	input logic off_req_i,
	output logic sys_rst_o,
	output logic halted_o
);

	localparam int CNT_BITS = $clog2(RST_HOLD_CYCLES + 1);

	logic [CNT_BITS-1:0] hold_cnt;
	logic off_q;
	logic sys_rst_q;

	// Output is registered so it lags the counter by one edge
	always_ff @(posedge clk48mhz_i) begin
		if (rst_p) begin
			hold_cnt <= CNT_BITS'(RST_HOLD_CYCLES);
			off_q <= 1'b0;
			sys_rst_q <= 1'b1;
		end else begin
			sys_rst_q <= (hold_cnt != '0) || off_q;
			if (warm_req_i)
				hold_cnt <= CNT_BITS'(RST_HOLD_CYCLES);
			else if (hold_cnt != '0)
				hold_cnt <= hold_cnt - 1'b1;
			// Stays set until the next rst_p
			if (off_req_i)
				off_q <= 1'b1;
		end
	end

	assign sys_rst_o = sys_rst_q;
	// Halted shows only once the bus is held in reset
	assign halted_o = off_q && sys_rst_q;

endmodule

`default_nettype wire

//--- rtl/int_ctrl.sv
// ----------------------------------------
// Interrupt controller: pending and enable
// registers with a registered request
// ----------------------------------------
`timescale 1ns/1ns
`default_nettype none

module int_ctrl (
	input logic clk48mhz_i,
	input logic sys_rst_i,
	pi1_if.slave bus,
	input logic [soc_pkg::INT_SRC_COUNT-1:0] irq_src_i,
	output logic irq_o
);

	localparam int IDX_BITS = $clog2(soc_pkg::MAPSZ_INTCTRL);
	localparam int N = soc_pkg::INT_SRC_COUNT;

	logic [IDX_BITS-1:0] word_idx;
	logic [N-1:0] pending;
	logic [N-1:0] enable;
	logic [N-1:0] clr_mask;
	logic [soc_pkg::ARCH_BITS-1:0] rd_word;
	logic [soc_pkg::ARCH_BITS-1:0] rdata_q;
	logic accept;
	logic do_wr;
	logic irq_q;

	assign word_idx = bus.addr[IDX_BITS-1:0];
	assign accept = bus.op != soc_pkg::OP_NONE && bus.rdy;
	assign do_wr = accept && (bus.op == soc_pkg::OP_WRITE || bus.op == soc_pkg::OP_SWAP)
		&& bus.sel[0];

	// Ones written to the pending word clear those bits
	assign clr_mask = (do_wr && word_idx == IDX_BITS'(soc_pkg::IC_PENDING)) ?
		bus.wdata[N-1:0] : '0;

	always_ff @(posedge clk48mhz_i) begin
		if (sys_rst_i) begin
			pending <= '0;
			enable <= '0;
			irq_q <= 1'b0;
		end else begin
			// A live source wins over a clear
			pending <= (pending & ~clr_mask) | irq_src_i;
			if (do_wr && word_idx == IDX_BITS'(soc_pkg::IC_ENABLE))
				enable <= bus.wdata[N-1:0];
			irq_q <= |(pending & enable);
		end
	end

	always_comb begin
		rd_word = '0;
		if (word_idx == IDX_BITS'(soc_pkg::IC_PENDING))
			rd_word[N-1:0] = pending;
		else if (word_idx == IDX_BITS'(soc_pkg::IC_ENABLE))
			rd_word[N-1:0] = enable;
	end

	always_ff @(posedge clk48mhz_i) begin
		if (accept && (bus.op == soc_pkg::OP_READ || bus.op == soc_pkg::OP_SWAP))
			rdata_q <= rd_word;
	end

	assign bus.rdata = rdata_q;
	assign bus.rdy = !sys_rst_i;
	assign irq_o = irq_q;

endmodule

`default_nettype wire

//--- rtl/dev_table.sv
// ----------------------------------------
// Device table with map description and
// the software reset control register
// ----------------------------------------
`timescale 1ns/1ns
`default_nettype none

module dev_table (
	input logic clk48mhz_i,
	input logic sys_rst_i,
	pi1_if.slave bus,
	output logic warm_req_o,
	output logic off_req_o
);

	localparam int IDX_BITS = $clog2(soc_pkg::MAPSZ_DEVTBL);
	localparam int DW = soc_pkg::ARCH_BITS;

	logic [IDX_BITS-1:0] word_idx;
	logic [DW-1:0] rd_word;
	logic [DW-1:0] rdata_q;
	logic accept;
	logic rst_wr;
	logic warm_q;
	logic off_q;

	assign word_idx = bus.addr[IDX_BITS-1:0];
	assign accept = bus.op != soc_pkg::OP_NONE && bus.rdy;

	// Each entry is an id word with useintr in bit 31, then a map size word
	always_comb begin
		rd_word = '0;
		case (word_idx)
			soc_pkg::DT_SOCID: rd_word = DW'(soc_pkg::SOC_ID);
			soc_pkg::DT_COUNT: rd_word = DW'(soc_pkg::SLAVE_COUNT);
			soc_pkg::DT_ENTRY + 0:
				rd_word = {soc_pkg::USEINTR_RAM, 31'(soc_pkg::DEV_ID_RAM)};
			soc_pkg::DT_ENTRY + 1: rd_word = DW'(soc_pkg::MAPSZ_RAM);
			soc_pkg::DT_ENTRY + 2:
				rd_word = {soc_pkg::USEINTR_DEVTBL, 31'(soc_pkg::DEV_ID_DEVTBL)};
			soc_pkg::DT_ENTRY + 3: rd_word = DW'(soc_pkg::MAPSZ_DEVTBL);
			soc_pkg::DT_ENTRY + 4:
				rd_word = {soc_pkg::USEINTR_INTCTRL, 31'(soc_pkg::DEV_ID_INTCTRL)};
			soc_pkg::DT_ENTRY + 5: rd_word = DW'(soc_pkg::MAPSZ_INTCTRL);
			default: rd_word = '0;
		endcase
	end

	always_ff @(posedge clk48mhz_i) begin
		if (accept && (bus.op == soc_pkg::OP_READ || bus.op == soc_pkg::OP_SWAP))
			rdata_q <= rd_word;
	end

	assign rst_wr = accept && (bus.op == soc_pkg::OP_WRITE || bus.op == soc_pkg::OP_SWAP)
		&& word_idx == IDX_BITS'(soc_pkg::DT_RSTCTRL) && bus.sel[0];

	// Bit 1 means warm reset (cold is folded in), bit 0 alone means power-off
	always_ff @(posedge clk48mhz_i) begin
		if (sys_rst_i) begin
			warm_q <= 1'b0;
			off_q <= 1'b0;
		end else begin
			warm_q <= rst_wr && bus.wdata[1];
			off_q <= rst_wr && bus.wdata[0] && !bus.wdata[1];
		end
	end

	assign warm_req_o = warm_q;
	assign off_req_o = off_q;
	assign bus.rdata = rdata_q;
	assign bus.rdy = !sys_rst_i;

endmodule

`default_nettype wire

//--- rtl/scratch_ram.sv
// ----------------------------------------
// Scratch RAM with byte selects and swap
// ----------------------------------------
`timescale 1ns/1ns
`default_nettype none

module scratch_ram (
	input logic clk48mhz_i,
	input logic sys_rst_i,
	pi1_if.slave bus
);

	localparam int IDX_BITS = $clog2(soc_pkg::MAPSZ_RAM);

	logic [soc_pkg::ARCH_BITS-1:0] mem [soc_pkg::MAPSZ_RAM];
	logic [soc_pkg::ARCH_BITS-1:0] rdata_q;
	logic [IDX_BITS-1:0] idx;
	logic accept;
	logic do_rd;
	logic do_wr;

	assign idx = bus.addr[IDX_BITS-1:0];
	assign accept = bus.op != soc_pkg::OP_NONE && bus.rdy;
	assign do_rd = accept && (bus.op == soc_pkg::OP_READ || bus.op == soc_pkg::OP_SWAP);
	assign do_wr = accept && (bus.op == soc_pkg::OP_WRITE || bus.op == soc_pkg::OP_SWAP);

	// Swap reads the old word since the write lands at the same edge
	always_ff @(posedge clk48mhz_i) begin
		if (do_rd)
			rdata_q <= mem[idx];
		if (do_wr) begin
			for (int b = 0; b < soc_pkg::SEL_BITS; b++) begin
				if (bus.sel[b])
					mem[idx][b*8 +: 8] <= bus.wdata[b*8 +: 8];
			end
		end
	end

	assign bus.rdata = rdata_q;
	assign bus.rdy = !sys_rst_i;

endmodule

`default_nettype wire

//--- rtl/pi1_router.sv
// ----------------------------------------
// PI1 router: decodes the word address and
// steers requests and read data
// ----------------------------------------
`timescale 1ns/1ns
`default_nettype none

module pi1_router (
	input logic clk48mhz_i,
	input logic sys_rst_i,
	pi1_if.slave host,
	pi1_if.master ram,
	pi1_if.master devtbl,
	pi1_if.master intc
);

	localparam int AW = soc_pkg::ADDR_BITS;

	// Regions lie back to back from address 0
	localparam logic [AW-1:0] BASE_RAM = '0;
	localparam logic [AW-1:0] BASE_DEVTBL = AW'(soc_pkg::MAPSZ_RAM);
	localparam logic [AW-1:0] BASE_INTCTRL = BASE_DEVTBL + AW'(soc_pkg::MAPSZ_DEVTBL);
	localparam logic [AW-1:0] BASE_INVALID = BASE_INTCTRL + AW'(soc_pkg::MAPSZ_INTCTRL);

	soc_pkg::slave_idx_t sel_idx;
	soc_pkg::slave_idx_t sel_q;
	logic slv_rdy;

	always_comb begin
		if (host.addr < BASE_DEVTBL)
			sel_idx = soc_pkg::S_RAM;
		else if (host.addr < BASE_INTCTRL)
			sel_idx = soc_pkg::S_DEVTBL;
		else if (host.addr < BASE_INVALID)
			sel_idx = soc_pkg::S_INTCTRL;
		else
			sel_idx = soc_pkg::S_INVALID;
	end

	// Only the matching region sees the operation
	always_comb begin
		ram.op = soc_pkg::OP_NONE;
		devtbl.op = soc_pkg::OP_NONE;
		intc.op = soc_pkg::OP_NONE;
		case (sel_idx)
			soc_pkg::S_RAM: ram.op = host.op;
			soc_pkg::S_DEVTBL: devtbl.op = host.op;
			soc_pkg::S_INTCTRL: intc.op = host.op;
			default: ;
		endcase
	end

	assign ram.addr = host.addr - BASE_RAM;
	assign devtbl.addr = host.addr - BASE_DEVTBL;
	assign intc.addr = host.addr - BASE_INTCTRL;
	assign ram.wdata = host.wdata;
	assign devtbl.wdata = host.wdata;
	assign intc.wdata = host.wdata;
	assign ram.sel = host.sel;
	assign devtbl.sel = host.sel;
	assign intc.sel = host.sel;

	// Invalid region is always ready
	always_comb begin
		case (sel_idx)
			soc_pkg::S_RAM: slv_rdy = ram.rdy;
			soc_pkg::S_DEVTBL: slv_rdy = devtbl.rdy;
			soc_pkg::S_INTCTRL: slv_rdy = intc.rdy;
			default: slv_rdy = 1'b1;
		endcase
	end

	assign host.rdy = slv_rdy && !sys_rst_i;

	// Remember which region answers the next cycle
	always_ff @(posedge clk48mhz_i) begin
		if (sys_rst_i)
			sel_q <= soc_pkg::S_INVALID;
		else if (host.op != soc_pkg::OP_NONE && host.rdy)
			sel_q <= sel_idx;
	end

	always_comb begin
		case (sel_q)
			soc_pkg::S_RAM: host.rdata = ram.rdata;
			soc_pkg::S_DEVTBL: host.rdata = devtbl.rdata;
			soc_pkg::S_INTCTRL: host.rdata = intc.rdata;
			default: host.rdata = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/pi1_if.sv
// ----------------------------------------
// PI1 bus between router and slaves
// ----------------------------------------
`timescale 1ns/1ns
`default_nettype none

interface pi1_if;

	soc_pkg::pi1_op_t op;
	// Word offset within the selected region
	logic [soc_pkg::ADDR_BITS-1:0] addr;
	logic [soc_pkg::ARCH_BITS-1:0] wdata;
	logic [soc_pkg::SEL_BITS-1:0] sel;
	logic [soc_pkg::ARCH_BITS-1:0] rdata;
	logic rdy;

	modport master (
		output op,
		output addr,
		output wdata,
		output sel,
		input rdata,
		input rdy
	);

	modport slave (
		input op,
		input addr,
		input wdata,
		input sel,
		output rdata,
		output rdy
	);

endinterface

`default_nettype wire

//--- rtl/soc_pkg.sv
// ----------------------------------------
// SoC package: bus widths, PI1 operations,
// slave map, device ids and register offsets
// ----------------------------------------
`default_nettype none

package soc_pkg;

	localparam int ARCH_BITS = 32;
	localparam int ADDR_BITS = ARCH_BITS - 2;
	localparam int SEL_BITS = ARCH_BITS / 8;

	// PI1 operation codes
	typedef enum logic [1:0] {
		OP_NONE  = 2'b00,
		OP_WRITE = 2'b01,
		OP_READ  = 2'b10,
		OP_SWAP  = 2'b11
	} pi1_op_t;

	// Regions in map order, invalid region last
	typedef enum logic [1:0] {
		S_RAM,
		S_DEVTBL,
		S_INTCTRL,
		S_INVALID
	} slave_idx_t;

	localparam int SLAVE_COUNT = 3;

	// Region sizes in words
	localparam int MAPSZ_RAM = 256;
	localparam int MAPSZ_DEVTBL = 64;
	localparam int MAPSZ_INTCTRL = 16;

	localparam int DEV_ID_RAM = 1;
	localparam int DEV_ID_DEVTBL = 7;
	localparam int DEV_ID_INTCTRL = 3;

	localparam bit USEINTR_RAM = 1'b0;
	localparam bit USEINTR_DEVTBL = 1'b0;
	localparam bit USEINTR_INTCTRL = 1'b0;

	localparam int SOC_ID = 6;

	localparam int INT_SRC_COUNT = 2;
	localparam int INT_SRC_SDCARD = 0;
	localparam int INT_SRC_SERIAL = 1;

	// Device table word offsets
	localparam int DT_SOCID = 0;
	localparam int DT_COUNT = 1;
	localparam int DT_RSTCTRL = 2;
	localparam int DT_ENTRY = 4;

	// Interrupt controller word offsets
	localparam int IC_PENDING = 0;
	localparam int IC_ENABLE = 1;

endpackage

`default_nettype wire
